// File: flist.f
logic/deser_pkg.sv
logic/serial_deser.sv
logic/rx_capture.sv
logic/deser_rx_top.sv
verification/deser_rx_chk.sv
verification/deser_rx_tb.sv

// File: Bender.yml
package:
  name: deser_rx

sources:
  - files:
      - logic/deser_pkg.sv
      - logic/serial_deser.sv
      - logic/rx_capture.sv
      - logic/deser_rx_top.sv
  - target: test
    files:
      - verification/deser_rx_chk.sv
      - verification/deser_rx_tb.sv

// File: verification/deser_rx_tb.sv
/*
 * Testbench for the serial receive channel top level. Drives seeded
 * random serial bits, enable and bitslip pulses, and checks data_o and
 * ready every cycle against a bit-level model of the channel rules.
 */

`timescale 1ns/1ps
`default_nettype none

module deser_rx_tb
    import deser_pkg::*;
;

    // ************************************************************************
    // Timing and test lengths
    // ************************************************************************

    localparam int CLK_PERIOD      = 100;               // ns
    localparam int STIM_DELAY      = 5;                 // Drive offset after rising edge
    localparam int RESET_CYCLES    = 4;                 // Lead-in edge plus 3 held low
    localparam int STABLE_CYCLES   = 20;
    localparam int STREAM_CYCLES   = 200;
    localparam int SLIP_CYCLES     = 300;
    localparam int DISABLE_CYCLES  = 100;
    localparam int PRE_CYCLES      = 50;
    localparam int POST_CYCLES     = 150;
    localparam int MARGIN_CYCLES   = 100;

    localparam int T1_CYCLES = RESET_CYCLES + SETTLE_CYCLES + STABLE_CYCLES;
    localparam int T2_CYCLES = RESET_CYCLES + SETTLE_CYCLES;
    localparam int T3_CYCLES = RESET_CYCLES + SETTLE_CYCLES + STREAM_CYCLES;
    localparam int T6_CYCLES = PRE_CYCLES + RESET_CYCLES + SETTLE_CYCLES + POST_CYCLES;
    localparam int WATCHDOG_CYCLES = T1_CYCLES + T2_CYCLES + T3_CYCLES + SLIP_CYCLES
                                   + DISABLE_CYCLES + T6_CYCLES + MARGIN_CYCLES;

    logic  fabric_clk_div = 1'b0;
    logic  reset_buf_n;
    logic  enable_n;
    logic  data_i;
    logic  bitslip_ctrl_n;
    word_t data_o;
    logic  ready;

    integer seed = 12712;                               // Fixed random seed
    int     err_count  = 0;
    int     pass_tests = 0;
    int     fail_tests = 0;
    int     errs_start;
    int     edges;

    // Reference model state
    word_t  m_hist;                                     // Last WIDTH sampled bits
    int     m_pos;                                      // Bit position in word
    logic   m_valid;                                    // Delayed word strobe
    word_t  m_word;                                     // Word carried by strobe
    int     m_settle;                                   // Edges since reset release
    logic   m_ready;
    word_t  m_data;                                     // Expected data_o

    always #(CLK_PERIOD / 2) fabric_clk_div = ~fabric_clk_div;

    deser_rx_top dut (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .enable_n       (enable_n),
        .data_i         (data_i),
        .bitslip_ctrl_n (bitslip_ctrl_n),
        .data_o         (data_o),
        .ready          (ready)
    );

    // ************************************************************************
    // Compare tasks
    // ************************************************************************

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
            err_count++;
        end
    endtask

    // ************************************************************************
    // Reference model, one call per rising edge
    // ************************************************************************

    task automatic model_step();
        logic bit_in;
        logic done;
        if (!reset_buf_n) begin
            m_hist   = '0;
            m_pos    = 0;
            m_valid  = 1'b0;
            m_word   = '0;
            m_settle = 0;
            m_ready  = 1'b0;
            m_data   = '0;
        end else begin
            bit_in = enable_n ? 1'b0 : data_i;          // Disabled input reads zero
            done   = (m_pos == WIDTH - 1) && bitslip_ctrl_n;
            if (m_valid && m_ready) begin
                m_data = m_word;                        // Capture uses state before edge
            end
            m_hist  = {m_hist[WIDTH-2:0], bit_in};      // Oldest bit ends in MSB
            m_valid = done;
            if (done) begin
                m_word = m_hist;
            end
            if (bitslip_ctrl_n) begin
                m_pos = (m_pos + 1) % WIDTH;            // Bitslip holds position
            end
            if (!m_ready) begin
                m_settle++;
                if (m_settle == SETTLE_CYCLES) begin
                    m_ready = 1'b1;
                end
            end
        end
    endtask

    // ************************************************************************
    // Stimulus and cycle helpers
    // ************************************************************************

    task automatic drive_inputs(input logic dis, input logic slips);
        logic [31:0] r;
        r        = $random(seed);
        data_i   = r[0];
        enable_n = dis;
        if (slips && bitslip_ctrl_n && (r[4:2] == 3'd0)) begin
            bitslip_ctrl_n = 1'b0;                      // Single-cycle pulse
        end else begin
            bitslip_ctrl_n = 1'b1;
        end
    endtask

    task automatic compare_outputs();
        check_word("data_o", m_data, data_o);
        check_ready("ready", m_ready, ready);
    endtask

    task automatic step(input logic dis, input logic slips);
        @(posedge fabric_clk_div);
        model_step();
        #STIM_DELAY;
        compare_outputs();                              // Outputs settled since the edge
        drive_inputs(dis, slips);
    endtask

    task automatic apply_reset();
        @(posedge fabric_clk_div);
        #STIM_DELAY;
        reset_buf_n    = 1'b0;
        enable_n       = 1'b1;
        data_i         = 1'b0;
        bitslip_ctrl_n = 1'b1;
        #1;
        check_word("data_o", '0, data_o);               // Async clear, no edge needed
        check_ready("ready", 1'b0, ready);
        repeat (3) begin
            @(posedge fabric_clk_div);
            model_step();
            #STIM_DELAY;
            compare_outputs();
        end
        reset_buf_n = 1'b1;
        drive_inputs(1'b0, 1'b0);
    endtask

    task automatic wait_for_ready(output int n);
        n = 0;
        while (!ready && n < SETTLE_CYCLES + 10) begin
            step(1'b0, 1'b0);
            n++;
        end
        if (!ready) begin
            $display("t=%0t ready did not rise within %0d cycles of reset release", $time, n);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("[TEST] %s ... ok", name);
        end else begin
            fail_tests++;
            $display("[TEST] %s ... %0d errors", name, err_count - errs_before);
        end
    endtask

    // ************************************************************************
    // Test sequence
    // ************************************************************************

    initial begin
        reset_buf_n    = 1'b1;
        enable_n       = 1'b1;
        data_i         = 1'b0;
        bitslip_ctrl_n = 1'b1;

        errs_start = err_count;                         // 1. Settle time
        apply_reset();
        wait_for_ready(edges);
        check_count("settle_edges", SETTLE_CYCLES, edges);
        repeat (STABLE_CYCLES) begin
            step(1'b0, 1'b0);
            check_ready("ready", 1'b1, ready);
        end
        report_test("settle time and stable ready", errs_start);

        errs_start = err_count;                         // 2. Output held before ready
        apply_reset();
        repeat (SETTLE_CYCLES) begin
            step(1'b0, 1'b0);
            if (!m_ready) begin
                check_word("data_o", '0, data_o);
            end
        end
        report_test("data_o zero while settling", errs_start);

        errs_start = err_count;                         // 3. Aligned random stream
        apply_reset();
        repeat (SETTLE_CYCLES + STREAM_CYCLES) begin
            step(1'b0, 1'b0);
        end
        report_test("aligned word stream", errs_start);

        errs_start = err_count;                         // 4. Random bitslip
        repeat (SLIP_CYCLES) begin
            step(1'b0, 1'b1);
        end
        report_test("bitslip boundary shift", errs_start);

        errs_start = err_count;                         // 5. Input disabled
        for (int i = 1; i <= DISABLE_CYCLES; i++) begin
            step(1'b1, 1'b0);
            if (i >= 2 * WIDTH + 2) begin
                check_word("data_o", '0, data_o);
            end
        end
        report_test("disabled input gives zero words", errs_start);

        errs_start = err_count;                         // 6. Reset mid-run
        repeat (PRE_CYCLES) begin
            step(1'b0, 1'b1);
        end
        apply_reset();
        wait_for_ready(edges);
        check_count("settle_edges", SETTLE_CYCLES, edges);
        repeat (POST_CYCLES) begin
            step(1'b0, 1'b1);
        end
        report_test("reset mid-run restarts channel", errs_start);

        if (dut.u_rx_capture.u_rx_chk.assert_fails != 0) begin
            $display("Assertion checker reported %0d failures",
                     dut.u_rx_capture.u_rx_chk.assert_fails);
        end
        $display("Summary: %0d tests passed, %0d tests failed", pass_tests, fail_tests);
        if (fail_tests == 0 && err_count == 0
            && dut.u_rx_capture.u_rx_chk.assert_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the summed test lengths
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout after %0d cycles, the run hung", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule : deser_rx_tb

`default_nettype wire

// File: verification/deser_rx_chk.sv
/*
 * Concurrent checks on the capture side of the receive channel.
 * Bound into every rx_capture instance. Covers strobe spacing, the
 * ready flag holding once set, and a frozen output while not ready.
 */

`timescale 1ns/1ps
`default_nettype none

module deser_rx_chk
    import deser_pkg::*;
(
    input logic     fabric_clk_div,                     // Fabric clock
    input logic     reset_buf_n,                        // Async reset, active low
    input rx_word_t rx_word,                            // Strobed word from deserializer
    input word_t    data_o,                             // Parallel output word
    input logic     ready                               // Channel settled
);

    int unsigned assert_fails = 0;                      // Read by the testbench at the end

    // ************************************************************************
    // Word path properties
    // ************************************************************************

    // Words are at least WIDTH cycles apart, bitslip only widens the gap
    a_strobe_gap : assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        rx_word.valid |=> !rx_word.valid [*(WIDTH-1)])
        else begin
            $error("rx_word.valid strobes closer than WIDTH cycles");
            assert_fails++;
        end

    a_ready_hold : assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        ready |=> ready)                                // Ready only clears by reset
        else begin
            $error("ready fell while out of reset");
            assert_fails++;
        end

    a_data_frozen : assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        !ready |=> $stable(data_o))                     // No capture while settling
        else begin
            $error("data_o changed while ready was low");
            assert_fails++;
        end

endmodule : deser_rx_chk

bind rx_capture deser_rx_chk u_rx_chk (
    .fabric_clk_div (fabric_clk_div),
    .reset_buf_n    (reset_buf_n),
    .rx_word        (rx_word),
    .data_o         (data_o),
    .ready          (ready)
);

`default_nettype wire

// File: logic/deser_rx_top.sv
/*
 * Top level of the serial receive channel. Connects the pins to the
 * deserializer input side and the capture block, which settles the
 * channel and drives the parallel output word and the ready flag.
 */

`timescale 1ns/1ps
`default_nettype none

module deser_rx_top
    import deser_pkg::*;
(
    input  logic  fabric_clk_div,                       // Fabric clock
    input  logic  reset_buf_n,                          // Async reset, active low
    input  logic  enable_n,                             // Active-low input enable
    input  logic  data_i,                               // Serial data in
    input  logic  bitslip_ctrl_n,                       // Active-low bitslip pulse
    output word_t data_o,                               // Parallel word out
    output logic  ready                                 // Channel ready
);

    // ************************************************************************
    // Internal word path
    // ************************************************************************

    rx_word_t rx_word;                                  // Deserializer to capture

    // Bit sampling and word assembly
    serial_deser u_serial_deser (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .enable_n       (enable_n),
        .data_i         (data_i),
        .bitslip_ctrl_n (bitslip_ctrl_n),
        .rx_word        (rx_word)
    );

    // Settle timer and output register
    rx_capture u_rx_capture (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .rx_word        (rx_word),
        .data_o         (data_o),
        .ready          (ready)
    );

endmodule : deser_rx_top

`default_nettype wire

// File: logic/rx_capture.sv
/*
 * Processing part of the receive channel. A settle timer keeps the
 * channel not-ready for SETTLE_CYCLES clocks after reset release.
 * Once ready, each strobed word from the deserializer is latched into
 * the parallel output register. Words arriving earlier are dropped.
 */

`timescale 1ns/1ps
`default_nettype none

module rx_capture
    import deser_pkg::*;
(
    input  logic     fabric_clk_div,                    // Fabric clock
    input  logic     reset_buf_n,                       // Async reset, active low
    input  rx_word_t rx_word,                           // Word and strobe from deserializer
    output word_t    data_o,                            // Parallel output word
    output logic     ready                              // Channel settled
);

    // ************************************************************************
    // Settle timer
    // ************************************************************************

    logic [SETTLE_CNT_W-1:0] settle_cnt;                // Cycles since reset release
    rx_state_e               state;                     // Receiver state
    logic                    settle_last;               // Final settle cycle
    logic                    capture;                   // Load output this edge

    assign settle_last = (settle_cnt == SETTLE_CNT_W'(SETTLE_CYCLES - 1));

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            settle_cnt <= '0;
        end else if (state == RX_SETTLING) begin
            settle_cnt <= settle_cnt + 1'b1;            // Frozen once ready
        end
    end

    // Count reaches SETTLE_CYCLES on the same edge the state flips
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            state <= RX_SETTLING;
        end else begin
            case (state)
                RX_SETTLING: begin
                    if (settle_last) begin
                        state <= RX_READY;
                    end
                end
                RX_READY: begin
                    state <= RX_READY;                  // Stays until reset
                end
                default: begin
                    state <= RX_SETTLING;
                end
            endcase
        end
    end

    assign ready = (state == RX_READY);

    // ************************************************************************
    // Output word register
    // ************************************************************************

    assign capture = rx_word.valid && (state == RX_READY); // Drop words while settling

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            data_o <= '0;
        end else if (capture) begin
            data_o <= rx_word.data;
        end
    end

endmodule : rx_capture

`default_nettype wire

// File: logic/serial_deser.sv
/*
 * Input side of the receive channel. Samples one serial bit per
 * fabric clock, forced to zero while the channel is disabled, and
 * assembles groups of WIDTH bits into words, oldest bit in the MSB.
 * A low bitslip pulse holds the bit counter, so the word boundary
 * moves one bit later. Each finished word leaves with a one-cycle strobe.
 */

`timescale 1ns/1ps
`default_nettype none

module serial_deser
    import deser_pkg::*;
(
    input  logic     fabric_clk_div,                    // Fabric clock, one bit per cycle
    input  logic     reset_buf_n,                       // Async reset, active low
    input  logic     enable_n,                          // Active-low input enable
    input  logic     data_i,                            // Serial data bit
    input  logic     bitslip_ctrl_n,                    // Active-low bitslip pulse
    output rx_word_t rx_word                            // Assembled word and strobe
);

    // ************************************************************************
    // Bit sampling
    // ************************************************************************

    logic                 sample_bit;                   // Gated serial bit
    logic [WIDTH-1:0]     shift_q;                      // Recent bit history
    logic [WIDTH-1:0]     shift_next;                   // History including this bit
    logic [BIT_CNT_W-1:0] bit_cnt;                      // Position within current word
    logic                 slip;                         // Bitslip requested this edge
    logic                 word_done;                    // Last bit of a word this edge
    word_t                word_q;                       // Finished word
    logic                 valid_q;                      // Strobe for finished word

    assign sample_bit = data_i & ~enable_n;             // Disabled input reads as zero
    assign shift_next = {shift_q[WIDTH-2:0], sample_bit}; // New bit enters at LSB
    assign slip       = ~bitslip_ctrl_n;

    // Word closes on the last position unless the counter is held
    assign word_done  = (bit_cnt == BIT_CNT_W'(WIDTH - 1)) && !slip;

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            shift_q <= '0;
        end else begin
            shift_q <= shift_next;                      // Shifts even during bitslip
        end
    end

    // ************************************************************************
    // Bit position counter with bitslip hold
    // ************************************************************************

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt <= '0;
        end else if (slip) begin
            bit_cnt <= bit_cnt;                         // Hold, boundary moves one bit later
        end else if (bit_cnt == BIT_CNT_W'(WIDTH - 1)) begin
            bit_cnt <= '0;                              // Wrap to first position
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // ************************************************************************
    // Word output register
    // ************************************************************************

    // Strobe is one cycle after the completing edge
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= word_done;
        end
    end

    // Payload, only loaded when a word closes
    always_ff @(posedge fabric_clk_div) begin
        if (word_done) begin
            word_q <= shift_next;                       // Oldest bit lands in MSB
        end
    end

    assign rx_word.data  = word_q;
    assign rx_word.valid = valid_q;

endmodule : serial_deser

`default_nettype wire

// File: logic/deser_pkg.sv
/*
 * Shared types and constants for the serial receive channel.
 * Holds the word type, the strobed word struct passed from the
 * deserializer to the capture block, the receiver state enum and
 * the settle timing. Import it into any block that needs these.
 */

`default_nettype none

package deser_pkg;

    // ************************************************************************
    // Word geometry and timing
    // ************************************************************************

    localparam int WIDTH         = 4;                   // Bits per parallel word
    localparam int BIT_CNT_W     = $clog2(WIDTH);       // Bit position counter width
    localparam int SETTLE_CYCLES = 255;                 // Not-ready time after reset
    localparam int SETTLE_CNT_W  = 8;                   // Settle counter width

    // ************************************************************************
    // Types
    // ************************************************************************

    typedef logic [WIDTH-1:0] word_t;                   // One parallel word, MSB first in time

    // Assembled word with its one-cycle strobe
    typedef struct packed {
        word_t data;                                    // Valid only with strobe
        logic  valid;                                   // High one cycle per word
    } rx_word_t;

    // Receiver readiness
    typedef enum logic {
        RX_SETTLING = 1'b0,                             // Settle timer running
        RX_READY    = 1'b1                              // Words pass to output
    } rx_state_e;

endpackage : deser_pkg

`default_nettype wire
